//--- common/p4_echo_defs.svh
// Echo router constants
// Port count, word width, buffer depth, credit and counter sizes

`ifndef P4_ECHO_DEFS_SVH
`define P4_ECHO_DEFS_SVH

// Physical ports, ingress and egress share the index
`define P4E_NUM_PORTS    2

// Data word width
`define P4E_WORD_BITS    32

// Words per echo buffer, also the initial ingress credit count
`define P4E_FIFO_DEPTH   8

// Initial egress credits granted by the sink
`define P4E_EGR_CREDITS  4

// Packet counter width
`define P4E_CNT_BITS     16

`endif

//--- common/p4_echo_pkg.sv
// Echo router types
// Data beats, per-port buses, port masks and packet counts

`default_nettype none

`include "p4_echo_defs.svh"

package p4_echo_pkg;

    ////////////////////////////////////////
    // Data path

    typedef logic [`P4E_WORD_BITS-1:0] word_t;

    // Last marks the final word of a packet
    typedef struct packed {
        word_t data;
        logic  last;
    } axis_beat_t;

    typedef axis_beat_t [`P4E_NUM_PORTS-1:0] beat_bus_t;

    // Valid flags, credit pulses and clears
    typedef logic [`P4E_NUM_PORTS-1:0] port_mask_t;

    ////////////////////////////////////////
    // Profiling

    typedef logic [`P4E_CNT_BITS-1:0] count_t;

    typedef count_t [`P4E_NUM_PORTS-1:0] count_bus_t;

endpackage

`default_nettype wire

//--- echo_path/port_echo_buffer.sv
// Per-port echo buffer
// Word FIFO gated by egress credits, returns an ingress credit per word read

`timescale 1ns/100ps
`default_nettype none

`include "p4_echo_defs.svh"

module port_echo_buffer (
    input  logic                    phys_port_clk_ifc,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  p4_echo_pkg::axis_beat_t in_beat,
    output logic                    out_valid,
    output p4_echo_pkg::axis_beat_t out_beat,
    input  logic                    egr_credit,
    output logic                    ing_credit
);

    localparam int PTR_BITS  = $clog2(`P4E_FIFO_DEPTH);
    localparam int FILL_BITS = $clog2(`P4E_FIFO_DEPTH + 1);
    localparam int CRED_BITS = $clog2(`P4E_EGR_CREDITS + 1);

    typedef logic [PTR_BITS-1:0]  ptr_t;
    typedef logic [FILL_BITS-1:0] fill_t;
    typedef logic [CRED_BITS-1:0] credit_t;

    p4_echo_pkg::axis_beat_t mem [0:`P4E_FIFO_DEPTH-1];

    ptr_t    wr_ptr;
    ptr_t    rd_ptr;
    fill_t   fill;
    credit_t egr_cred;
    logic    rd_en;

    // A word leaves only when one is stored and the sink has room
    assign rd_en = (fill != '0) && (egr_cred != '0);

    ////////////////////////////////////////
    // Storage

    always_ff @(posedge phys_port_clk_ifc) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_beat;
        end
        if (rd_en) begin
            out_beat <= mem[rd_ptr];
        end
    end

    ////////////////////////////////////////
    // Pointers, fill level and credits

    always_ff @(posedge phys_port_clk_ifc) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            egr_cred   <= credit_t'(`P4E_EGR_CREDITS);
            out_valid  <= 1'b0;
            ing_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == ptr_t'(`P4E_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ptr_t'(`P4E_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end

            case ({in_valid, rd_en})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase

            case ({rd_en, egr_credit})
                2'b10:   egr_cred <= egr_cred - 1'b1;
                2'b01:   egr_cred <= egr_cred + 1'b1;
                default: egr_cred <= egr_cred;
            endcase

            out_valid <= rd_en;
            // Credit back to the source the cycle after the egress transfer
            ing_credit <= out_valid;
        end
    end

endmodule

`default_nettype wire

//--- profile/pkt_profile_counter.sv
// Packet profile counter
// Counts completed packets per port at one observation point

`timescale 1ns/100ps
`default_nettype none

`include "p4_echo_defs.svh"

module pkt_profile_counter (
    input  logic                    phys_port_clk_ifc,
    input  logic                    rst_n,
    input  p4_echo_pkg::port_mask_t beat_valid,
    input  p4_echo_pkg::beat_bus_t  beats,
    input  p4_echo_pkg::port_mask_t cnt_clear,
    output p4_echo_pkg::count_bus_t pkt_cnt
);

    p4_echo_pkg::port_mask_t pkt_done;

    // End of packet seen on a port
    always_comb begin
        for (int p = 0; p < `P4E_NUM_PORTS; p++) begin
            pkt_done[p] = beat_valid[p] && beats[p].last;
        end
    end

    ////////////////////////////////////////
    // Counters

    always_ff @(posedge phys_port_clk_ifc) begin
        if (!rst_n) begin
            pkt_cnt <= '0;
        end else begin
            for (int p = 0; p < `P4E_NUM_PORTS; p++) begin
                // Clear wins over a packet ending in the same cycle
                if (cnt_clear[p]) begin
                    pkt_cnt[p] <= '0;
                end else if (pkt_done[p]) begin
                    pkt_cnt[p] <= pkt_cnt[p] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- profile/in_flight_tracker.sv
// In-flight tracker
// Outstanding packets per port from ingress and egress counts, plus idle flag

`timescale 1ns/100ps
`default_nettype none

`include "p4_echo_defs.svh"

module in_flight_tracker (
    input  logic                    phys_port_clk_ifc,
    input  logic                    rst_n,
    input  p4_echo_pkg::count_bus_t ing_cnt,
    input  p4_echo_pkg::count_bus_t egr_cnt,
    output p4_echo_pkg::count_bus_t in_flight,
    output logic                    all_idle
);

    p4_echo_pkg::count_bus_t diff;

    // Modular difference, correct across counter wrap
    always_comb begin
        for (int p = 0; p < `P4E_NUM_PORTS; p++) begin
            diff[p] = ing_cnt[p] - egr_cnt[p];
        end
    end

    ////////////////////////////////////////
    // Registered outputs

    always_ff @(posedge phys_port_clk_ifc) begin
        if (!rst_n) begin
            in_flight <= '0;
            all_idle  <= 1'b1;
        end else begin
            in_flight <= diff;
            // Idle only when no port has a packet outstanding
            all_idle  <= (diff == '0);
        end
    end

endmodule

`default_nettype wire

//--- src/p4_echo_router.sv
// Physical port echo router
// Echoes each ingress port onto the same egress port and profiles packet counts

`timescale 1ns/100ps
`default_nettype none

`include "p4_echo_defs.svh"

module p4_echo_router (
    input  logic                    phys_port_clk_ifc,
    input  logic                    rst_n,
    input  p4_echo_pkg::port_mask_t ing_valid,
    input  p4_echo_pkg::beat_bus_t  ing_beats,
    output p4_echo_pkg::port_mask_t ing_credit,
    output p4_echo_pkg::port_mask_t egr_valid,
    output p4_echo_pkg::beat_bus_t  egr_beats,
    input  p4_echo_pkg::port_mask_t egr_credit,
    input  p4_echo_pkg::port_mask_t cnt_clear,
    output p4_echo_pkg::count_bus_t ing_cnt,
    output p4_echo_pkg::count_bus_t egr_cnt,
    output p4_echo_pkg::count_bus_t in_flight,
    output logic                    all_idle
);

    ////////////////////////////////////////
    // Echo path, one buffer per port

    for (genvar p = 0; p < `P4E_NUM_PORTS; p++) begin : g_port
        port_echo_buffer u_buffer (
            .phys_port_clk_ifc ( phys_port_clk_ifc ),
            .rst_n             ( rst_n             ),
            .in_valid          ( ing_valid[p]      ),
            .in_beat           ( ing_beats[p]      ),
            .out_valid         ( egr_valid[p]      ),
            .out_beat          ( egr_beats[p]      ),
            .egr_credit        ( egr_credit[p]     ),
            .ing_credit        ( ing_credit[p]     )
        );
    end

    ////////////////////////////////////////
    // Packet profiling

    // Accepted ingress beats
    pkt_profile_counter u_ing_profile (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst_n             ( rst_n             ),
        .beat_valid        ( ing_valid         ),
        .beats             ( ing_beats         ),
        .cnt_clear         ( cnt_clear         ),
        .pkt_cnt           ( ing_cnt           )
    );

    // Delivered egress beats
    pkt_profile_counter u_egr_profile (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst_n             ( rst_n             ),
        .beat_valid        ( egr_valid         ),
        .beats             ( egr_beats         ),
        .cnt_clear         ( cnt_clear         ),
        .pkt_cnt           ( egr_cnt           )
    );

    in_flight_tracker u_in_flight (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst_n             ( rst_n             ),
        .ing_cnt           ( ing_cnt           ),
        .egr_cnt           ( egr_cnt           ),
        .in_flight         ( in_flight         ),
        .all_idle          ( all_idle          )
    );

endmodule

`default_nettype wire

//--- tests/p4_echo_router_tb.sv
// Echo router testbench
// Table-driven packets through a credit-limited source and a randomly delaying sink

`timescale 1ns/100ps
`default_nettype none

`include "p4_echo_defs.svh"

module p4_echo_router_tb;

    localparam int NUM_PORTS = `P4E_NUM_PORTS;
    localparam int NUM_PKTS  = 10;
    localparam int TIMEOUT   = 1000;

    typedef struct packed {
        int port;
        int len;
        bit clear_after;
        bit watch_drain;
    } pkt_entry_t;

    // Port, words, clear the port afterwards, watch in_flight while it drains
    pkt_entry_t pkt_table [NUM_PKTS] = '{
        '{0,  1, 1'b0, 1'b0},
        '{1,  4, 1'b0, 1'b0},
        '{0,  6, 1'b0, 1'b0},
        '{1, 20, 1'b0, 1'b1},
        '{0,  3, 1'b1, 1'b0},
        '{1,  2, 1'b0, 1'b0},
        '{0,  5, 1'b0, 1'b0},
        '{1, 12, 1'b1, 1'b1},
        '{0,  9, 1'b0, 1'b0},
        '{1,  1, 1'b0, 1'b0}
    };

    logic                    phys_port_clk_ifc = 1'b0;
    logic                    rst_n;
    p4_echo_pkg::port_mask_t ing_valid;
    p4_echo_pkg::beat_bus_t  ing_beats;
    p4_echo_pkg::port_mask_t ing_credit;
    p4_echo_pkg::port_mask_t egr_valid;
    p4_echo_pkg::beat_bus_t  egr_beats;
    p4_echo_pkg::port_mask_t egr_credit;
    p4_echo_pkg::port_mask_t cnt_clear;
    p4_echo_pkg::count_bus_t ing_cnt;
    p4_echo_pkg::count_bus_t egr_cnt;
    p4_echo_pkg::count_bus_t in_flight;
    logic                    all_idle;

    p4_echo_pkg::axis_beat_t exp_q [NUM_PORTS][$];
    int unsigned             credit_due [NUM_PORTS][$];
    int                      sent [NUM_PORTS];
    int                      exp_pkts [NUM_PORTS];
    int                      ing_returned [NUM_PORTS];
    int                      egr_returned [NUM_PORTS];
    int                      egr_seen [NUM_PORTS];

    always #50 phys_port_clk_ifc = ~phys_port_clk_ifc;

    p4_echo_router u_dut (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst_n             ( rst_n             ),
        .ing_valid         ( ing_valid         ),
        .ing_beats         ( ing_beats         ),
        .ing_credit        ( ing_credit        ),
        .egr_valid         ( egr_valid         ),
        .egr_beats         ( egr_beats         ),
        .egr_credit        ( egr_credit        ),
        .cnt_clear         ( cnt_clear         ),
        .ing_cnt           ( ing_cnt           ),
        .egr_cnt           ( egr_cnt           ),
        .in_flight         ( in_flight         ),
        .all_idle          ( all_idle          )
    );

    task automatic flag_mismatch(input string what);
        $display("[ERROR] %0t: %s", $time, what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    ////////////////////////////////////////
    // Sink and monitors

    always @(posedge phys_port_clk_ifc) begin : ingress_credit_count
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!rst_n) begin
                ing_returned[p] <= 0;
            end else if (ing_credit[p]) begin
                ing_returned[p] <= ing_returned[p] + 1;
            end
        end
    end

    // Each egress word returns its credit 0 to 5 cycles later, one per cycle
    initial begin : egress_sink
        int unsigned cycle;
        int unsigned delay;
        cycle = 0;
        egr_credit <= '0;
        forever begin
            @(posedge phys_port_clk_ifc);
            cycle = cycle + 1;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (!rst_n) begin
                    credit_due[p].delete();
                    egr_credit[p]   <= 1'b0;
                    egr_returned[p] <= 0;
                end else begin
                    if (egr_valid[p]) begin
                        delay = $urandom_range(5, 0);
                        credit_due[p].push_back(cycle + delay);
                    end
                    if (credit_due[p].size() != 0 && credit_due[p][0] <= cycle) begin
                        void'(credit_due[p].pop_front());
                        egr_credit[p]   <= 1'b1;
                        egr_returned[p] <= egr_returned[p] + 1;
                    end else begin
                        egr_credit[p] <= 1'b0;
                    end
                end
            end
        end
    end

    always @(posedge phys_port_clk_ifc) begin : egress_monitor
        p4_echo_pkg::axis_beat_t exp_beat;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!rst_n) begin
                egr_seen[p] = 0;
            end else if (egr_valid[p]) begin
                assert (exp_q[p].size() != 0) else flag_mismatch($sformatf(
                    "unexpected word %h on egress port %0d", egr_beats[p].data, p));
                exp_beat = exp_q[p].pop_front();
                assert (egr_beats[p] == exp_beat) else flag_mismatch($sformatf(
                    "port %0d got %h last %b, expected %h last %b", p, egr_beats[p].data,
                    egr_beats[p].last, exp_beat.data, exp_beat.last));
                egr_seen[p] = egr_seen[p] + 1;
                assert (egr_seen[p] <= `P4E_EGR_CREDITS + egr_returned[p]) else
                    flag_mismatch($sformatf("port %0d sent words beyond its egress credits", p));
            end
        end
    end

    ////////////////////////////////////////
    // Source and drain tasks

    task automatic send_packet(input int port, input int len);
        p4_echo_pkg::axis_beat_t beat;
        p4_echo_pkg::port_mask_t mask;
        int waited;
        mask = '0;
        mask[port] = 1'b1;
        for (int i = 0; i < len; i++) begin
            waited = 0;
            @(posedge phys_port_clk_ifc);
            assert (ing_returned[port] <= sent[port]) else
                flag_mismatch($sformatf("port %0d returned more ingress credits than words sent",
                    port));
            // Hold off while every credit is spent
            while (sent[port] - ing_returned[port] >= `P4E_FIFO_DEPTH) begin
                ing_valid <= '0;
                waited++;
                if (waited > TIMEOUT) abort_on_timeout("an ingress credit");
                @(posedge phys_port_clk_ifc);
            end
            beat.data = p4_echo_pkg::word_t'($urandom());
            beat.last = (i == len - 1);
            ing_valid       <= mask;
            ing_beats[port] <= beat;
            sent[port]++;
            exp_q[port].push_back(beat);
        end
        @(posedge phys_port_clk_ifc);
        ing_valid <= '0;
        exp_pkts[port]++;
    endtask

    function automatic bit path_quiet();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (exp_q[p].size() != 0 || sent[p] != ing_returned[p]) begin
                return 1'b0;
            end
        end
        return all_idle;
    endfunction

    task automatic drain_all();
        int waited;
        waited = 0;
        @(negedge phys_port_clk_ifc);
        while (!path_quiet()) begin
            waited++;
            if (waited > TIMEOUT) abort_on_timeout("all ports to drain");
            @(negedge phys_port_clk_ifc);
        end
    endtask

    task automatic watch_drain(input int port);
        int waited;
        waited = 0;
        @(negedge phys_port_clk_ifc);
        while (in_flight[port] == '0) begin
            assert (exp_q[port].size() != 0) else flag_mismatch($sformatf(
                "port %0d drained before in_flight rose", port));
            waited++;
            if (waited > TIMEOUT) abort_on_timeout("in_flight to rise");
            @(negedge phys_port_clk_ifc);
        end
        while (exp_q[port].size() != 0) begin
            assert (in_flight[port] != '0 && !all_idle) else flag_mismatch($sformatf(
                "port %0d in_flight %0d all_idle %b while the packet drains", port,
                in_flight[port], all_idle));
            waited++;
            if (waited > TIMEOUT) abort_on_timeout("the long packet to drain");
            @(negedge phys_port_clk_ifc);
        end
        while (in_flight[port] != '0) begin
            waited++;
            if (waited > TIMEOUT) abort_on_timeout("in_flight to return to 0");
            @(negedge phys_port_clk_ifc);
        end
    endtask

    task automatic clear_port(input int port);
        p4_echo_pkg::count_bus_t ing_before;
        p4_echo_pkg::count_bus_t egr_before;
        drain_all();
        ing_before = ing_cnt;
        egr_before = egr_cnt;
        @(posedge phys_port_clk_ifc);
        cnt_clear[port] <= 1'b1;
        @(posedge phys_port_clk_ifc);
        cnt_clear <= '0;
        @(negedge phys_port_clk_ifc);
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (p == port) begin
                assert (ing_cnt[p] == '0 && egr_cnt[p] == '0) else
                    flag_mismatch($sformatf("port %0d counts not cleared", p));
            end else begin
                assert (ing_cnt[p] == ing_before[p] && egr_cnt[p] == egr_before[p]) else
                    flag_mismatch($sformatf("clear of port %0d changed port %0d", port, p));
            end
        end
        exp_pkts[port] = 0;
    endtask

    ////////////////////////////////////////
    // Main sequence

    initial begin : stimulus
        int port;
        void'($urandom(75430));
        rst_n      <= 1'b0;
        ing_valid  <= '0;
        ing_beats  <= '0;
        cnt_clear  <= '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            sent[p]     = 0;
            exp_pkts[p] = 0;
        end
        repeat (2) @(posedge phys_port_clk_ifc);
        rst_n <= 1'b1;
        @(negedge phys_port_clk_ifc);
        assert (all_idle && ing_cnt == '0 && egr_cnt == '0 && in_flight == '0 &&
                egr_valid == '0 && ing_credit == '0) else
            flag_mismatch("outputs not at their reset values");

        for (int i = 0; i < NUM_PKTS; i++) begin
            port = pkt_table[i].port;
            send_packet(port, pkt_table[i].len);
            if (pkt_table[i].watch_drain) begin
                watch_drain(port);
            end
            if (pkt_table[i].clear_after) begin
                clear_port(port);
            end
        end

        drain_all();
        for (int p = 0; p < NUM_PORTS; p++) begin
            assert (ing_cnt[p] == p4_echo_pkg::count_t'(exp_pkts[p]) &&
                    egr_cnt[p] == p4_echo_pkg::count_t'(exp_pkts[p]) &&
                    in_flight[p] == '0) else
                flag_mismatch($sformatf("port %0d ing %0d egr %0d in_flight %0d, expected %0d",
                    p, ing_cnt[p], egr_cnt[p], in_flight[p], exp_pkts[p]));
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+common
common/p4_echo_pkg.sv
echo_path/port_echo_buffer.sv
profile/pkt_profile_counter.sv
profile/in_flight_tracker.sv
src/p4_echo_router.sv
tests/p4_echo_router_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the echo router testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module p4_echo_router_tb -f vlog.f -Mdir obj_dir

./obj_dir/Vp4_echo_router_tb
